//--- src/bru_dq_pkg.sv
// shared widths, branch opcodes and payload types for the BRU dispatch queue
// the writeback bus is banked on the low PR bits; the tag holds the rest
// opcode encoding follows the funct3 pattern for conditional branches

`default_nettype none

package bru_dq_pkg;

    // ------------------------------------------------------------------------
    // widths

    parameter int DISPATCH_WAYS = 4;

    parameter int LOG_PR_COUNT = 7;
    parameter int LOG_PRF_BANK_COUNT = 2;
    parameter int PRF_BANK_COUNT = 2 ** LOG_PRF_BANK_COUNT;
    parameter int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    parameter int LOG_ROB_ENTRIES = 7;

    // ------------------------------------------------------------------------
    // branch opcodes

    typedef enum logic [3:0] {
        BRU_OP_JALR  = 4'b0000,
        BRU_OP_JAL   = 4'b0010,
        BRU_OP_LUI   = 4'b0110,
        BRU_OP_AUIPC = 4'b0111,
        BRU_OP_BEQ   = 4'b1000,
        BRU_OP_BNE   = 4'b1001,
        BRU_OP_BLT   = 4'b1100,
        BRU_OP_BGE   = 4'b1101,
        BRU_OP_BLTU  = 4'b1110,
        BRU_OP_BGEU  = 4'b1111
    } bru_op_e;

    // ------------------------------------------------------------------------
    // payloads

    // one queued branch op
    typedef struct packed {
        bru_op_e                    op;
        logic                       is_link_ra;
        logic                       is_ret_ra;
        logic [31:0]                pc;
        logic [19:0]                imm20;
        logic [LOG_PR_COUNT-1:0]    a_pr;
        logic                       a_ready;
        logic                       a_unneeded_or_is_zero;
        logic [LOG_PR_COUNT-1:0]    b_pr;
        logic                       b_ready;
        logic                       b_unneeded_or_is_zero;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_payload_t;

    // one writeback bank, selected by the low PR bits
    typedef struct packed {
        logic                      valid;
        logic [UPPER_PR_WIDTH-1:0] upper_pr;
    } wb_bank_t;

endpackage

`default_nettype wire

//--- src/dispatch_alloc.sv
// assigns each attempting dispatch way the lowest free entry, in way order
// free means invalid in the current state; a launch this cycle frees nothing
// an attempt without valid still takes its slot and is acked
// purely combinational

`timescale 1ns/1ps
`default_nettype none

module dispatch_alloc #(
    parameter int DQ_ENTRIES = 4
) (
    input  logic [DQ_ENTRIES-1:0]                                entry_valid,

    input  logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                 dispatch_attempt,
    input  logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                 dispatch_valid,
    input  bru_dq_pkg::bru_payload_t [bru_dq_pkg::DISPATCH_WAYS-1:0] dispatch_payload,
    output logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                 dispatch_ack,

    output logic [DQ_ENTRIES-1:0]                                entry_dispatch_valid,
    output bru_dq_pkg::bru_payload_t [DQ_ENTRIES-1:0]            entry_dispatch_payload
);

    import bru_dq_pkg::*;

    // ------------------------------------------------------------------------
    // signals

    // entries still open when each way gets its turn
    logic [DISPATCH_WAYS-1:0][DQ_ENTRIES-1:0] open_mask;
    logic [DISPATCH_WAYS-1:0][DQ_ENTRIES-1:0] lowest_open;
    logic [DISPATCH_WAYS-1:0][DQ_ENTRIES-1:0] grant;

    // assertion helpers
    logic [DQ_ENTRIES-1:0] granted_any;
    logic                  grant_conflict;

    // ------------------------------------------------------------------------
    // priority chain

    for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_way
        if (w == 0) begin : g_first
            assign open_mask[w] = ~entry_valid;
        end
        else begin : g_later
            assign open_mask[w] = open_mask[w-1] & ~grant[w-1];
        end

        // lowest set bit of the open mask
        assign lowest_open[w] = open_mask[w] & (~open_mask[w] + 1'b1);

        assign grant[w] = lowest_open[w] & {DQ_ENTRIES{dispatch_attempt[w]}};

        // acked whenever a slot is left, valid or not
        assign dispatch_ack[w] = dispatch_attempt[w] & (|open_mask[w]);
    end

    // ------------------------------------------------------------------------
    // way to entry crossbar

    // grants are one-hot per entry, so OR-ing is a mux
    always_comb begin
        entry_dispatch_valid = '0;
        entry_dispatch_payload = '0;
        for (int e = 0; e < DQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (grant[w][e]) begin
                    entry_dispatch_valid[e] = entry_dispatch_valid[e] | dispatch_valid[w];
                    entry_dispatch_payload[e] =
                        bru_payload_t'(entry_dispatch_payload[e] | dispatch_payload[w]);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks

    always_comb begin
        granted_any = '0;
        grant_conflict = 1'b0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            grant_conflict = grant_conflict | (|(granted_any & grant[w]));
            granted_any = granted_any | grant[w];
        end
        grant_conflict = grant_conflict | (|(granted_any & entry_valid));
    end

    // no two ways on one entry, and never onto an occupied entry
    a_grants_disjoint: assert final (!grant_conflict)
        else $error("dispatch grants overlap or target an occupied entry");

endmodule

`default_nettype wire

//--- src/wb_wakeup.sv
// flags operands woken by this cycle's writeback bus, per entry
// the low PR bits pick the bank, the upper bits must match its tag
// combinational; entry validity is not considered here

`timescale 1ns/1ps
`default_nettype none

module wb_wakeup #(
    parameter int DQ_ENTRIES = 4
) (
    input  bru_dq_pkg::wb_bank_t [bru_dq_pkg::PRF_BANK_COUNT-1:0] wb_bus,

    input  logic [DQ_ENTRIES-1:0][bru_dq_pkg::LOG_PR_COUNT-1:0]   a_pr_by_entry,
    input  logic [DQ_ENTRIES-1:0][bru_dq_pkg::LOG_PR_COUNT-1:0]   b_pr_by_entry,

    output logic [DQ_ENTRIES-1:0]                                 new_a_ready,
    output logic [DQ_ENTRIES-1:0]                                 new_b_ready
);

    import bru_dq_pkg::*;

    // tag match against the bank this PR lives in
    function automatic logic pr_woken(
        input logic [LOG_PR_COUNT-1:0]        pr,
        input wb_bank_t [PRF_BANK_COUNT-1:0]  bus
    );
        wb_bank_t bank;
        bank = bus[pr[LOG_PRF_BANK_COUNT-1:0]];
        return bank.valid & (bank.upper_pr == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            new_a_ready[i] = pr_woken(a_pr_by_entry[i], wb_bus);
            new_b_ready[i] = pr_woken(b_pr_by_entry[i], wb_bus);
        end
    end

endmodule

`default_nettype wire

//--- src/dq_entry_array.sv
// compacting shift queue; the oldest op always sits in entry 0
// on launch every entry takes the one above it, or that entry's dispatch
// wakeups merge into held entries and into the launching head
// a dispatch landing this cycle does not see this cycle's wakeup

`timescale 1ns/1ps
`default_nettype none

module dq_entry_array #(
    parameter int DQ_ENTRIES = 4
) (
    input  logic                                                 CLK,
    input  logic                                                 nRST,

    input  logic [DQ_ENTRIES-1:0]                                entry_dispatch_valid,
    input  bru_dq_pkg::bru_payload_t [DQ_ENTRIES-1:0]            entry_dispatch_payload,

    input  logic [DQ_ENTRIES-1:0]                                new_a_ready,
    input  logic [DQ_ENTRIES-1:0]                                new_b_ready,

    input  logic                                                 iq_enq_ready,

    output logic [DQ_ENTRIES-1:0]                                entry_valid,
    output logic [DQ_ENTRIES-1:0][bru_dq_pkg::LOG_PR_COUNT-1:0]  a_pr_by_entry,
    output logic [DQ_ENTRIES-1:0][bru_dq_pkg::LOG_PR_COUNT-1:0]  b_pr_by_entry,

    output logic                                                 iq_enq_valid,
    output bru_dq_pkg::bru_payload_t                             iq_enq_payload
);

    import bru_dq_pkg::*;

    // ------------------------------------------------------------------------
    // signals

    logic [DQ_ENTRIES-1:0]        valid_q;
    logic [DQ_ENTRIES-1:0]        valid_d;
    bru_payload_t [DQ_ENTRIES-1:0] payload_q;
    bru_payload_t [DQ_ENTRIES-1:0] payload_d;

    // one extra empty slot above the top entry, so entry i can read i+1
    logic [DQ_ENTRIES:0]          valid_ext;
    logic [DQ_ENTRIES:0]          dispatch_valid_ext;
    bru_payload_t [DQ_ENTRIES:0]  held_ext;
    bru_payload_t [DQ_ENTRIES:0]  dispatch_payload_ext;

    logic                         launching;

    // ------------------------------------------------------------------------
    // wakeup merge and head launch

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            held_ext[i] = payload_q[i];
            held_ext[i].a_ready = payload_q[i].a_ready | new_a_ready[i];
            held_ext[i].b_ready = payload_q[i].b_ready | new_b_ready[i];
            dispatch_payload_ext[i] = entry_dispatch_payload[i];
        end
        held_ext[DQ_ENTRIES] = '0;
        dispatch_payload_ext[DQ_ENTRIES] = '0;
    end

    assign valid_ext = {1'b0, valid_q};
    assign dispatch_valid_ext = {1'b0, entry_dispatch_valid};

    assign launching = valid_q[0] & iq_enq_ready;

    assign iq_enq_valid = launching;
    assign iq_enq_payload = held_ext[0];

    // ------------------------------------------------------------------------
    // next state

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            if (launching) begin
                // shift down by one
                if (valid_ext[i+1]) begin
                    valid_d[i] = 1'b1;
                    payload_d[i] = held_ext[i+1];
                end
                else begin
                    valid_d[i] = dispatch_valid_ext[i+1];
                    payload_d[i] = dispatch_payload_ext[i+1];
                end
            end
            else if (valid_q[i]) begin
                valid_d[i] = 1'b1;
                payload_d[i] = held_ext[i];
            end
            else begin
                valid_d[i] = entry_dispatch_valid[i];
                payload_d[i] = entry_dispatch_payload[i];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_q <= '0;
        end
        else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        payload_q <= payload_d;
    end

    // ------------------------------------------------------------------------
    // outputs to allocation and wakeup

    assign entry_valid = valid_q;

    always_comb begin
        for (int i = 0; i < DQ_ENTRIES; i++) begin
            a_pr_by_entry[i] = payload_q[i].a_pr;
            b_pr_by_entry[i] = payload_q[i].b_pr;
        end
    end

    // occupied entries form a run from entry 0, with no holes
    a_valid_contiguous: assert property (
        @(posedge CLK) disable iff (!nRST)
        (valid_q & (valid_q + 1'b1)) == '0
    ) else $error("queue valid bits not contiguous: %b", valid_q);

endmodule

`default_nettype wire

//--- src/bru_dq_top.sv
// BRU dispatch queue: up to DISPATCH_WAYS ops in per cycle, one out to the IQ
// acks are combinational and depend on the current occupancy only
// DQ_ENTRIES must be 2 or more

`timescale 1ns/1ps
`default_nettype none

module bru_dq_top #(
    parameter int DQ_ENTRIES = 4
) (
    input  logic                                                     CLK,
    input  logic                                                     nRST,

    // dispatch by way
    input  logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                     dispatch_attempt,
    input  logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                     dispatch_valid,
    input  bru_dq_pkg::bru_payload_t [bru_dq_pkg::DISPATCH_WAYS-1:0] dispatch_payload,
    output logic [bru_dq_pkg::DISPATCH_WAYS-1:0]                     dispatch_ack,

    // writeback bus by bank
    input  bru_dq_pkg::wb_bank_t [bru_dq_pkg::PRF_BANK_COUNT-1:0]    wb_bus,

    // enqueue to issue queue
    output logic                                                     iq_enq_valid,
    output bru_dq_pkg::bru_payload_t                                 iq_enq_payload,
    input  logic                                                     iq_enq_ready
);

    import bru_dq_pkg::*;

    logic [DQ_ENTRIES-1:0]                    entry_valid;
    logic [DQ_ENTRIES-1:0]                    entry_dispatch_valid;
    bru_payload_t [DQ_ENTRIES-1:0]            entry_dispatch_payload;

    logic [DQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]  a_pr_by_entry;
    logic [DQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]  b_pr_by_entry;
    logic [DQ_ENTRIES-1:0]                    new_a_ready;
    logic [DQ_ENTRIES-1:0]                    new_b_ready;

    dispatch_alloc #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) alloc0 (
        .entry_valid            (entry_valid),
        .dispatch_attempt       (dispatch_attempt),
        .dispatch_valid         (dispatch_valid),
        .dispatch_payload       (dispatch_payload),
        .dispatch_ack           (dispatch_ack),
        .entry_dispatch_valid   (entry_dispatch_valid),
        .entry_dispatch_payload (entry_dispatch_payload)
    );

    wb_wakeup #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) wakeup0 (
        .wb_bus        (wb_bus),
        .a_pr_by_entry (a_pr_by_entry),
        .b_pr_by_entry (b_pr_by_entry),
        .new_a_ready   (new_a_ready),
        .new_b_ready   (new_b_ready)
    );

    dq_entry_array #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) entries0 (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .entry_dispatch_valid   (entry_dispatch_valid),
        .entry_dispatch_payload (entry_dispatch_payload),
        .new_a_ready            (new_a_ready),
        .new_b_ready            (new_b_ready),
        .iq_enq_ready           (iq_enq_ready),
        .entry_valid            (entry_valid),
        .a_pr_by_entry          (a_pr_by_entry),
        .b_pr_by_entry          (b_pr_by_entry),
        .iq_enq_valid           (iq_enq_valid),
        .iq_enq_payload         (iq_enq_payload)
    );

endmodule

`default_nettype wire

//--- tests/tb_bru_dq.sv
// directed tests for the BRU dispatch queue, DQ_ENTRIES fixed at 4
// a scoreboard queue tracks the ops held in the DUT, oldest first
// inputs change on the falling edge; outputs are sampled 1 ns later

`timescale 1ns/1ps
`default_nettype none

module tb_bru_dq;

    import bru_dq_pkg::*;

    localparam int DQ_ENTRIES = 4;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    // the tests need under 100 cycles; generous margin on top
    localparam int WATCHDOG_CYCLES = 1000;

    logic                                  CLK;
    logic                                  nRST;
    logic [DISPATCH_WAYS-1:0]              dispatch_attempt;
    logic [DISPATCH_WAYS-1:0]              dispatch_valid;
    bru_payload_t [DISPATCH_WAYS-1:0]      dispatch_payload;
    logic [DISPATCH_WAYS-1:0]              dispatch_ack;
    wb_bank_t [PRF_BANK_COUNT-1:0]         wb_bus;
    logic                                  iq_enq_valid;
    bru_payload_t                          iq_enq_payload;
    logic                                  iq_enq_ready;

    logic [31:0]  lfsr_state = 32'h7e15c0dc;
    int           errors = 0;
    int           checks = 0;
    bru_payload_t way_payload [DISPATCH_WAYS];
    bru_payload_t model_q [$];
    bru_op_e      op_table [10] = '{BRU_OP_JALR, BRU_OP_JAL, BRU_OP_BEQ, BRU_OP_BNE,
                                    BRU_OP_BLT, BRU_OP_BGE, BRU_OP_BLTU, BRU_OP_BGEU,
                                    BRU_OP_AUIPC, BRU_OP_LUI};

    bru_dq_top #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) dut0 (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_valid   (dispatch_valid),
        .dispatch_payload (dispatch_payload),
        .dispatch_ack     (dispatch_ack),
        .wb_bus           (wb_bus),
        .iq_enq_valid     (iq_enq_valid),
        .iq_enq_payload   (iq_enq_payload),
        .iq_enq_ready     (iq_enq_ready)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ------------------------------------------------------------------------
    // stimulus helpers

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic make_payload(output bru_payload_t p);
        logic [31:0] r;
        p = '0;
        take_bits(4, r);
        p.op = op_table[int'(r % 10)];
        take_bits(2, r);
        p.is_link_ra = r[1];
        p.is_ret_ra = r[0];
        take_bits(32, r);
        p.pc = r;
        take_bits(20, r);
        p.imm20 = r[19:0];
        take_bits(LOG_PR_COUNT + 2, r);
        p.a_pr = r[LOG_PR_COUNT+1:2];
        p.a_ready = r[1];
        p.a_unneeded_or_is_zero = r[0];
        take_bits(LOG_PR_COUNT + 2, r);
        p.b_pr = r[LOG_PR_COUNT+1:2];
        p.b_ready = r[1];
        p.b_unneeded_or_is_zero = r[0];
        take_bits(LOG_PR_COUNT, r);
        p.dest_pr = r[LOG_PR_COUNT-1:0];
        take_bits(LOG_ROB_ENTRIES, r);
        p.rob_index = r[LOG_ROB_ENTRIES-1:0];
    endtask

    // low PR bits select the bank, upper bits must equal its tag
    function automatic logic operand_woken(input logic [LOG_PR_COUNT-1:0] pr,
                                           input wb_bank_t [PRF_BANK_COUNT-1:0] bus);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return bus[bank].valid && (bus[bank].upper_pr == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    // ------------------------------------------------------------------------
    // one cycle: drive, check against the scoreboard, update the scoreboard

    task automatic run_cycle(input logic [DISPATCH_WAYS-1:0] attempt,
                             input logic [DISPATCH_WAYS-1:0] valid, input logic ready,
                             input wb_bank_t [PRF_BANK_COUNT-1:0] bus);
        int                       free_slots;
        logic [DISPATCH_WAYS-1:0] exp_ack;
        logic                     exp_enq;
        bru_payload_t             item;
        @(negedge CLK);
        dispatch_attempt = attempt;
        dispatch_valid = valid;
        iq_enq_ready = ready;
        wb_bus = bus;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            dispatch_payload[w] = way_payload[w];
        end
        #1;
        // wakeups reach held ops only, not this cycle's dispatches
        for (int i = 0; i < model_q.size(); i++) begin
            item = model_q[i];
            item.a_ready = item.a_ready | operand_woken(item.a_pr, bus);
            item.b_ready = item.b_ready | operand_woken(item.b_pr, bus);
            model_q[i] = item;
        end
        free_slots = DQ_ENTRIES - model_q.size();
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            exp_ack[w] = attempt[w] && (free_slots > 0);
            if (exp_ack[w]) begin
                free_slots--;
            end
        end
        exp_enq = (model_q.size() > 0) && ready;
        checks += 2;
        assert (dispatch_ack === exp_ack) else begin
            errors++;
            $display("ERR %0t: dispatch_ack %b, expected %b", $time, dispatch_ack, exp_ack);
        end
        assert (iq_enq_valid === exp_enq) else begin
            errors++;
            $display("ERR %0t: iq_enq_valid %b, expected %b", $time, iq_enq_valid, exp_enq);
        end
        if (model_q.size() > 0) begin
            checks++;
            assert (iq_enq_payload === model_q[0]) else begin
                errors++;
                $display("ERR %0t: head payload %h, expected %h",
                         $time, iq_enq_payload, model_q[0]);
            end
        end
        if (exp_enq) begin
            void'(model_q.pop_front());
        end
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (exp_ack[w] && valid[w]) begin
                model_q.push_back(way_payload[w]);
            end
        end
    endtask

    task automatic drain_queue();
        while (model_q.size() > 0) begin
            run_cycle('0, '0, 1'b1, '0);
        end
        // one more cycle to see the queue empty
        run_cycle('0, '0, 1'b1, '0);
    endtask

    task automatic expect_bit(input logic actual, input logic expected, input string what);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // tests

    task automatic test_after_reset();
        run_cycle(4'b1010, 4'b0000, 1'b1, '0);
        run_cycle(4'b0101, 4'b0000, 1'b1, '0);
        run_cycle(4'b1111, 4'b0000, 1'b1, '0);
        run_cycle(4'b0000, 4'b0000, 1'b1, '0);
    endtask

    task automatic test_four_way_dispatch();
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            make_payload(way_payload[w]);
        end
        run_cycle(4'b1111, 4'b1111, 1'b1, '0);
        drain_queue();
    endtask

    task automatic test_fill_when_stalled();
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            make_payload(way_payload[w]);
        end
        run_cycle(4'b0111, 4'b0111, 1'b0, '0);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            make_payload(way_payload[w]);
        end
        run_cycle(4'b1111, 4'b1111, 1'b0, '0);
        expect_bit(dispatch_ack == 4'b0001, 1'b1, "only way 0 acked");
        // full now, nothing more gets in
        run_cycle(4'b1111, 4'b1111, 1'b0, '0);
        drain_queue();
    endtask

    task automatic test_hold_under_backpressure();
        bru_payload_t first;
        make_payload(way_payload[0]);
        make_payload(way_payload[1]);
        first = way_payload[0];
        run_cycle(4'b0011, 4'b0011, 1'b0, '0);
        repeat (5) begin
            run_cycle('0, '0, 1'b0, '0);
            expect_bit(iq_enq_valid, 1'b0, "iq_enq_valid while stalled");
            expect_bit(iq_enq_payload == first, 1'b1, "head payload held");
        end
        drain_queue();
    endtask

    task automatic test_wakeup();
        bru_payload_t                     p;
        wb_bank_t [PRF_BANK_COUNT-1:0]    bus;
        logic [LOG_PRF_BANK_COUNT-1:0]    bank;
        logic [UPPER_PR_WIDTH-1:0]        tag;
        make_payload(p);
        p.a_ready = 1'b0;
        p.b_ready = 1'b1;
        way_payload[0] = p;
        bank = p.a_pr[LOG_PRF_BANK_COUNT-1:0];
        tag = p.a_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        run_cycle(4'b0001, 4'b0001, 1'b0, '0);
        // wrong tag on the right bank
        bus = '0;
        bus[bank] = '{valid: 1'b1, upper_pr: tag ^ 1'b1};
        run_cycle('0, '0, 1'b0, bus);
        expect_bit(iq_enq_payload.a_ready, 1'b0, "a_ready after tag mismatch");
        // right tag on the wrong bank
        bus = '0;
        bus[bank ^ 1'b1] = '{valid: 1'b1, upper_pr: tag};
        run_cycle('0, '0, 1'b0, bus);
        expect_bit(iq_enq_payload.a_ready, 1'b0, "a_ready after bank mismatch");
        bus = '0;
        bus[bank] = '{valid: 1'b1, upper_pr: tag};
        run_cycle('0, '0, 1'b0, bus);
        expect_bit(iq_enq_payload.a_ready, 1'b1, "a_ready on wakeup cycle");
        run_cycle('0, '0, 1'b0, '0);
        expect_bit(iq_enq_payload.a_ready, 1'b1, "a_ready held after wakeup");
        run_cycle('0, '0, 1'b1, '0);
        expect_bit(iq_enq_valid & iq_enq_payload.a_ready, 1'b1, "a_ready at launch");
        drain_queue();
    endtask

    task automatic test_attempt_without_valid();
        make_payload(way_payload[0]);
        run_cycle(4'b0001, 4'b0001, 1'b0, '0);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            make_payload(way_payload[w]);
        end
        // way 2 takes the last free entry but leaves it empty
        run_cycle(4'b1111, 4'b1011, 1'b0, '0);
        expect_bit(dispatch_ack == 4'b0111, 1'b1, "way 3 refused");
        way_payload[0] = way_payload[3];
        run_cycle(4'b0001, 4'b0001, 1'b0, '0);
        drain_queue();
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog

    initial begin
        $timeformat(-9, 0, " ns", 0);
        CLK = 1'b0;
        nRST = 1'b0;
        dispatch_attempt = '0;
        dispatch_valid = '0;
        dispatch_payload = '0;
        wb_bus = '0;
        iq_enq_ready = 1'b1;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            way_payload[w] = '0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        test_after_reset();
        test_four_way_dispatch();
        test_fill_when_stalled();
        test_hold_under_backpressure();
        test_wakeup();
        test_attempt_without_valid();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog expired: the tests did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/bru_dq_pkg.sv
src/dispatch_alloc.sv
src/wb_wakeup.sv
src/dq_entry_array.sv
src/bru_dq_top.sv
tests/tb_bru_dq.sv
